//--- logic/soc_pkg.sv
`default_nettype none

package soc_pkg;

    localparam int unsigned WINDOW_BITS = 12;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0] be_t;
    typedef logic [WINDOW_BITS-1:0] slave_addr_t;
    typedef logic [9:0] ram_word_addr_t;

    typedef enum logic {
        RAM_IDLE,
        RAM_ACK
    } ram_state_t;

    localparam addr_t RAM_BASE    = 32'h0000_0000;
    localparam addr_t GPIO_BASE   = 32'h1000_0000;
    localparam addr_t TICKER_BASE = 32'h1000_1000;

    localparam slave_addr_t GPIO_OUT_OFS = 12'h000;
    localparam slave_addr_t GPIO_IN_OFS  = 12'h004;

    localparam slave_addr_t TICK_COUNT_OFS = 12'h000;
    localparam slave_addr_t TICK_CMP_OFS   = 12'h004;
    localparam slave_addr_t TICK_CTRL_OFS  = 12'h008;
    localparam slave_addr_t TICK_STAT_OFS  = 12'h00C;

    // byte lane n of the result comes from new_w when be[n] is set
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, be_t be);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

//--- logic/slave_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface slave_bus_if
    import soc_pkg::*;
();

    slave_addr_t address;    // local byte offset inside the window
    be_t         byteenable;
    word_t       wrdata;
    logic        read;
    logic        write;
    word_t       rddata;
    logic        stall;

    modport master (
        output address,
        output byteenable,
        output wrdata,
        output read,
        output write,
        input  rddata,
        input  stall
    );

    modport slave (
        input  address,
        input  byteenable,
        input  wrdata,
        input  read,
        input  write,
        output rddata,
        output stall
    );

endinterface

`default_nettype wire

//--- logic/dbus.sv
`timescale 1ns/1ps
`default_nettype none

module dbus
    import soc_pkg::*;
(
    input  wire logic   clk_i,
    input  wire logic   rst_n_i,
    input  wire addr_t  master_address_i,
    input  wire be_t    master_byteenable_i,
    input  wire logic   master_read_i,
    input  wire logic   master_write_i,
    input  wire word_t  master_wrdata_i,
    output word_t       master_rddata_o,
    output logic        master_stall_o,
    slave_bus_if.master ram_o,
    slave_bus_if.master gpio_o,
    slave_bus_if.master ticker_o
);

    logic ram_hit;
    logic gpio_hit;
    logic ticker_hit;

    assign ram_hit    = master_address_i[31:WINDOW_BITS] == RAM_BASE[31:WINDOW_BITS];
    assign gpio_hit   = master_address_i[31:WINDOW_BITS] == GPIO_BASE[31:WINDOW_BITS];
    assign ticker_hit = master_address_i[31:WINDOW_BITS] == TICKER_BASE[31:WINDOW_BITS];

    assign ram_o.address    = master_address_i[WINDOW_BITS-1:0];
    assign ram_o.byteenable = master_byteenable_i;
    assign ram_o.wrdata     = master_wrdata_i;
    assign ram_o.read       = master_read_i & ram_hit;
    assign ram_o.write      = master_write_i & ram_hit;

    assign gpio_o.address    = master_address_i[WINDOW_BITS-1:0];
    assign gpio_o.byteenable = master_byteenable_i;
    assign gpio_o.wrdata     = master_wrdata_i;
    assign gpio_o.read       = master_read_i & gpio_hit;
    assign gpio_o.write      = master_write_i & gpio_hit;

    assign ticker_o.address    = master_address_i[WINDOW_BITS-1:0];
    assign ticker_o.byteenable = master_byteenable_i;
    assign ticker_o.wrdata     = master_wrdata_i;
    assign ticker_o.read       = master_read_i & ticker_hit;
    assign ticker_o.write      = master_write_i & ticker_hit;

    always_comb begin
        master_rddata_o = '0; // an unmapped access reads zero and never stalls
        master_stall_o  = 1'b0;
        if (ram_hit) begin
            master_rddata_o = ram_o.rddata;
            master_stall_o  = ram_o.stall;
        end else if (gpio_hit) begin
            master_rddata_o = gpio_o.rddata;
            master_stall_o  = gpio_o.stall;
        end else if (ticker_hit) begin
            master_rddata_o = ticker_o.rddata;
            master_stall_o  = ticker_o.stall;
        end
    end

    a_rw_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(master_read_i && master_write_i));

    a_one_slave: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({ram_o.read | ram_o.write,
                  gpio_o.read | gpio_o.write,
                  ticker_o.read | ticker_o.write}));

endmodule

`default_nettype wire

//--- logic/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import soc_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_n_i,
    slave_bus_if.slave bus_i
);

    word_t          mem [1024];
    word_t          rd_q;
    ram_state_t     state_q;
    ram_state_t     state_d;
    ram_word_addr_t word_idx;
    logic           access;

    assign word_idx = bus_i.address[11:2];
    assign access   = bus_i.read | bus_i.write;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RAM_IDLE: begin
                if (access) begin
                    state_d = RAM_ACK;
                end
            end
            RAM_ACK: begin
                state_d = RAM_IDLE; // the master sees stall low here and moves on
            end
            default: begin
                state_d = RAM_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RAM_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // the array is touched only in the first cycle, the held request is then acknowledged
    always_ff @(posedge clk_i) begin
        if (state_q == RAM_IDLE && bus_i.write) begin
            mem[word_idx] <= merge_bytes(mem[word_idx], bus_i.wrdata, bus_i.byteenable);
        end
        if (state_q == RAM_IDLE && bus_i.read) begin
            rd_q <= mem[word_idx];
        end
    end

    assign bus_i.stall  = (state_q == RAM_IDLE) && access;
    assign bus_i.rddata = rd_q;

    a_held_in_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q == RAM_ACK) |-> access);

endmodule

`default_nettype wire

//--- logic/gpio_top.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_top
    import soc_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_n_i,
    slave_bus_if.slave bus_i,
    input  wire word_t gpio_i,
    output word_t      gpio_o
);

    word_t out_q;
    word_t meta_q;
    word_t in_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q  <= '0;
            meta_q <= '0;
            in_q   <= '0;
        end else begin
            meta_q <= gpio_i; // pins are asynchronous to the bus clock
            in_q   <= meta_q;
            if (bus_i.write && bus_i.address == GPIO_OUT_OFS) begin
                out_q <= merge_bytes(out_q, bus_i.wrdata, bus_i.byteenable);
            end
        end
    end

    always_comb begin
        case (bus_i.address)
            GPIO_OUT_OFS: bus_i.rddata = out_q;
            GPIO_IN_OFS:  bus_i.rddata = in_q;
            default:      bus_i.rddata = '0;
        endcase
    end

    assign bus_i.stall = 1'b0;
    assign gpio_o      = out_q;

endmodule

`default_nettype wire

//--- logic/ticker.sv
`timescale 1ns/1ps
`default_nettype none

module ticker
    import soc_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_n_i,
    slave_bus_if.slave bus_i,
    output logic       irq_o
);

    word_t count_q;
    word_t cmp_q;
    logic  en_q;
    logic  pend_q;
    logic  loaded_q;
    logic  count_wr;
    logic  clear;
    logic  match;

    assign count_wr = bus_i.write && bus_i.address == TICK_COUNT_OFS;
    assign clear    = bus_i.write && bus_i.address == TICK_STAT_OFS
                      && bus_i.byteenable[0] && bus_i.wrdata[0];
    // a stopped counter only matches right after software loaded it
    assign match    = (count_q == cmp_q) && (en_q || loaded_q);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q  <= '0;
            cmp_q    <= '0;
            en_q     <= 1'b0;
            pend_q   <= 1'b0;
            loaded_q <= 1'b0;
        end else begin
            loaded_q <= count_wr;
            if (count_wr) begin
                count_q <= merge_bytes(count_q, bus_i.wrdata, bus_i.byteenable);
            end else if (en_q) begin
                count_q <= count_q + 32'd1;
            end
            if (bus_i.write && bus_i.address == TICK_CMP_OFS) begin
                cmp_q <= merge_bytes(cmp_q, bus_i.wrdata, bus_i.byteenable);
            end
            if (bus_i.write && bus_i.address == TICK_CTRL_OFS && bus_i.byteenable[0]) begin
                en_q <= bus_i.wrdata[0];
            end
            if (match) begin
                pend_q <= 1'b1; // a fresh match beats a clear in the same cycle
            end else if (clear) begin
                pend_q <= 1'b0;
            end
        end
    end

    always_comb begin
        case (bus_i.address)
            TICK_COUNT_OFS: bus_i.rddata = count_q;
            TICK_CMP_OFS:   bus_i.rddata = cmp_q;
            TICK_CTRL_OFS:  bus_i.rddata = {31'd0, en_q};
            TICK_STAT_OFS:  bus_i.rddata = {31'd0, pend_q};
            default:        bus_i.rddata = '0;
        endcase
    end

    assign bus_i.stall = 1'b0;
    assign irq_o       = pend_q;

    a_no_pend_when_off: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(pend_q) |-> ($past(en_q) || $past(loaded_q)));

endmodule

`default_nettype wire

//--- logic/soc_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top
    import soc_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_n_i,
    input  wire addr_t master_address_i,
    input  wire be_t   master_byteenable_i,
    input  wire logic  master_read_i,
    input  wire logic  master_write_i,
    input  wire word_t master_wrdata_i,
    output word_t      master_rddata_o,
    output logic       master_stall_o,
    input  wire word_t gpio_i,
    output word_t      gpio_o,
    output logic       irq_o
);

    slave_bus_if ram_bus ();
    slave_bus_if gpio_bus ();
    slave_bus_if ticker_bus ();

    dbus i_dbus (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .master_address_i    (master_address_i),
        .master_byteenable_i (master_byteenable_i),
        .master_read_i       (master_read_i),
        .master_write_i      (master_write_i),
        .master_wrdata_i     (master_wrdata_i),
        .master_rddata_o     (master_rddata_o),
        .master_stall_o      (master_stall_o),
        .ram_o               (ram_bus.master),
        .gpio_o              (gpio_bus.master),
        .ticker_o            (ticker_bus.master)
    );

    data_ram i_data_ram (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus_i   (ram_bus.slave)
    );

    gpio_top i_gpio (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus_i   (gpio_bus.slave),
        .gpio_i  (gpio_i),
        .gpio_o  (gpio_o)
    );

    ticker i_ticker (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus_i   (ticker_bus.slave),
        .irq_o   (irq_o) // the only interrupt source in this subsystem
    );

endmodule

`default_nettype wire

//--- testbench/tb_soc_bus.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus
    import soc_pkg::*;
();

    logic  clk_i;
    logic  rst_n_i;
    addr_t master_address_i;
    be_t   master_byteenable_i;
    logic  master_read_i;
    logic  master_write_i;
    word_t master_wrdata_i;
    word_t master_rddata_o;
    logic  master_stall_o;
    word_t gpio_i;
    word_t gpio_o;
    logic  irq_o;

    string op_q[$];
    addr_t addr_q[$];
    be_t   be_q[$];
    word_t data_q[$];
    word_t exp_q[$];
    string name_q[$];

    int    error_count = 0;
    int    check_count = 0;
    logic  ops_loaded  = 1'b0;
    int    seed        = 97857;
    word_t shadow [1024];

    soc_bus_top i_dut (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .master_address_i    (master_address_i),
        .master_byteenable_i (master_byteenable_i),
        .master_read_i       (master_read_i),
        .master_write_i      (master_write_i),
        .master_wrdata_i     (master_wrdata_i),
        .master_rddata_o     (master_rddata_o),
        .master_stall_o      (master_stall_o),
        .gpio_i              (gpio_i),
        .gpio_o              (gpio_o),
        .irq_o               (irq_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i; // 8 ns period
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("ERROR %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_irq(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("ERROR %s: expected irq %b, actual irq %b", name, exp, act);
        end
    endtask

    task automatic check_stalls(input string name, input int exp, input int act);
        check_count++;
        if (act != exp) begin
            error_count++;
            $display("ERROR %s: expected %0d stall cycles, actual %0d", name, exp, act);
        end
    endtask

    // only the 4 KiB RAM window above RAM_BASE inserts a wait state
    function automatic int expected_stalls(input addr_t addr);
        return ((addr - RAM_BASE) < 32'h0000_1000) ? 1 : 0;
    endfunction

    // starts on a falling edge and returns on the falling edge after completion
    task automatic bus_access(input logic wr, input addr_t addr, input be_t be,
                              input word_t wdata, output word_t rdata, output int stalls);
        logic stalled;
        master_address_i    = addr;
        master_byteenable_i = be;
        master_wrdata_i     = wdata;
        master_write_i      = wr;
        master_read_i       = !wr;
        stalls              = 0;
        do begin
            @(posedge clk_i);
            stalled = master_stall_o;
            rdata   = master_rddata_o;
            if (stalled) begin
                stalls++;
            end
        end while (stalled);
        @(negedge clk_i);
        master_read_i  = 1'b0;
        master_write_i = 1'b0;
    endtask

    task automatic read_input();
        int    fd;
        int    code;
        logic  done;
        string tok;
        string rest;
        addr_t addr;
        be_t   be;
        word_t data;
        word_t exp;
        string name;
        done = 1'b0;
        fd   = $fopen("testbench/dbus_input.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("could not open testbench/dbus_input.txt");
        end else begin
            while (!done) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    done = 1'b1;
                end else if (tok.substr(0, 0) == "#") begin
                    code = $fgets(rest, fd); // skip the rest of a comment line
                end else begin
                    code = $fscanf(fd, "%h %h %h %h %s", addr, be, data, exp, name);
                    if (code != 5) begin
                        error_count++;
                        $display("malformed line after opcode %s in input file", tok);
                        done = 1'b1;
                    end else begin
                        op_q.push_back(tok);
                        addr_q.push_back(addr);
                        be_q.push_back(be);
                        data_q.push_back(data);
                        exp_q.push_back(exp);
                        name_q.push_back(name);
                    end
                end
            end
            $fclose(fd);
        end
        ops_loaded = 1'b1;
    endtask

    task automatic run_op(input int i);
        word_t rdata;
        int    stalls;
        int    waited;
        if (op_q[i] == "W") begin
            bus_access(1'b1, addr_q[i], be_q[i], data_q[i], rdata, stalls);
            check_stalls(name_q[i], expected_stalls(addr_q[i]), stalls);
        end else if (op_q[i] == "R") begin
            bus_access(1'b0, addr_q[i], be_q[i], '0, rdata, stalls);
            check_stalls(name_q[i], expected_stalls(addr_q[i]), stalls);
            check_word(name_q[i], exp_q[i], rdata);
        end else if (op_q[i] == "G") begin
            gpio_i = data_q[i];
            repeat (3) @(negedge clk_i);
            check_word(name_q[i], exp_q[i], gpio_o);
        end else if (op_q[i] == "I") begin
            waited = 0;
            // nonzero data waits for the rise, at most one 64-cycle line budget
            while (data_q[i] != '0 && !irq_o && waited < 64) begin
                @(negedge clk_i);
                waited++;
            end
            check_irq(name_q[i], exp_q[i][0], irq_o);
        end else begin
            error_count++;
            $display("unknown opcode %s in test %s", op_q[i], name_q[i]);
        end
    endtask

    initial begin : stimulus
        ram_word_addr_t fill_idx[$];
        ram_word_addr_t idx;
        word_t          rnd;
        word_t          wdata;
        word_t          rdata;
        int             stalls;
        rst_n_i             = 1'b0;
        master_address_i    = '0;
        master_byteenable_i = '0;
        master_read_i       = 1'b0;
        master_write_i      = 1'b0;
        master_wrdata_i     = '0;
        gpio_i              = '0;
        read_input();
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        for (int i = 0; i < op_q.size(); i++) begin
            run_op(i);
        end

        for (int k = 0; k < 16; k++) begin
            rnd   = $random(seed);
            idx   = rnd[9:0];
            wdata = $random(seed);
            shadow[idx] = wdata; // a repeated index keeps the newest word
            fill_idx.push_back(idx);
            bus_access(1'b1, RAM_BASE + {20'h0, idx, 2'b00}, 4'hf, wdata, rdata, stalls);
            check_stalls($sformatf("ram_fill_wr_%0d", k), 1, stalls);
        end
        foreach (fill_idx[k]) begin
            bus_access(1'b0, RAM_BASE + {20'h0, fill_idx[k], 2'b00}, 4'hf, '0, rdata, stalls);
            check_stalls($sformatf("ram_fill_rd_%0d", k), 1, stalls);
            check_word($sformatf("ram_fill_rd_%0d", k), shadow[fill_idx[k]], rdata);
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (ops_loaded);
        repeat ((op_q.size() + 16) * 64 + 2000) @(posedge clk_i);
        $display("watchdog timeout: irq or bus never completed");
        $display("checks: %0d, errors: %0d", check_count, error_count + 1);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- soc_bus.f
logic/soc_pkg.sv
logic/slave_bus_if.sv
logic/dbus.sv
logic/data_ram.sv
logic/gpio_top.sv
logic/ticker.sv
logic/soc_bus_top.sv
testbench/tb_soc_bus.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TB_TOP   = tb_soc_bus
RTL_TOP  = soc_bus_top
FILELIST = soc_bus.f
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TB_TOP)
	./obj_dir/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/dbus_input.txt
# op addr be data expected name
# W write, R read and compare, G drive gpio_i then check gpio_o, I check irq_o (data 1 waits)
W 00000000 f 11223344 00000000 ram_full_wr
W 00000000 3 aabbccdd 00000000 ram_be_wr
R 00000000 f 00000000 1122ccdd ram_be_merge
W 10000000 f 0f0f0f0f 00000000 gpio_out_wr
W 10000000 4 00a50000 00000000 gpio_out_partial
G 00000000 0 5a5a1234 0fa50f0f gpio_out_pins
R 10000004 f 00000000 5a5a1234 gpio_in_rd
W 10001000 f 00000123 00000000 tick_count_wr
W 10001004 f 00000028 00000000 tick_cmp_wr
R 10001000 f 00000000 00000123 tick_count_rd
W 20000000 f deadbeef 00000000 unmapped_wr
R 20000000 f 00000000 00000000 unmapped_rd
R 00000000 f 00000000 1122ccdd ram_keep
R 10000000 f 00000000 0fa50f0f gpio_keep
R 10001000 f 00000000 00000123 tick_count_keep
R 10001004 f 00000000 00000028 tick_cmp_keep
W 10001000 f 00000000 00000000 tick_count_zero
W 10001008 f 00000001 00000000 tick_enable
R 10001008 f 00000000 00000001 tick_ctrl_rd
I 00000000 0 00000001 00000001 tick_irq_rise
R 1000100c f 00000000 00000001 tick_stat_rd
W 1000100c f 00000001 00000000 tick_stat_clr
I 00000000 0 00000000 00000000 tick_irq_clear
